// ==== mem_net.sv ====
// two-port memory network: credit-based request router, valid/ready response router
// banks must accept every valid request and copy src and domain into the response
`timescale 1ns/1ps
`default_nettype none

module mem_net #(
	parameter int p_credits     = 2,
	parameter int p_single_bank = 0
) (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    mode,

	input  mem_net_pkg::mem_req_t   req_in_msg_p0,
	input  logic                    req_in_val_p0,
	output logic                    req_in_rdy_p0,
	output mem_net_pkg::proc_resp_t resp_out_msg_p0,
	output logic                    resp_out_val_p0,
	input  logic                    resp_out_rdy_p0,

	input  mem_net_pkg::mem_req_t   req_in_msg_p1,
	input  logic                    req_in_val_p1,
	output logic                    req_in_rdy_p1,
	output mem_net_pkg::proc_resp_t resp_out_msg_p1,
	output logic                    resp_out_val_p1,
	input  logic                    resp_out_rdy_p1,

	// bank side
	output mem_net_pkg::req_net_t   req_out_msg_p0,
	output logic                    req_out_val_p0,
	input  logic                    req_out_credit_p0,
	input  mem_net_pkg::resp_net_t  resp_in_msg_p0,
	input  logic                    resp_in_val_p0,
	output logic                    resp_in_rdy_p0,

	output mem_net_pkg::req_net_t   req_out_msg_p1,
	output logic                    req_out_val_p1,
	input  logic                    req_out_credit_p1,
	input  mem_net_pkg::resp_net_t  resp_in_msg_p1,
	input  logic                    resp_in_val_p1,
	output logic                    resp_in_rdy_p1
);

	mem_net_pkg::req_net_t  req_net_p0;
	mem_net_pkg::req_net_t  req_net_p1;
	mem_net_pkg::resp_net_t resp_net_p0;
	mem_net_pkg::resp_net_t resp_net_p1;

	//====================================================================
	// request path
	//====================================================================

	mem_net_req_decode #(.p_port(0), .p_single_bank(p_single_bank)) req_decode_p0 (
		.mode    (mode),
		.mem_msg (req_in_msg_p0),
		.net_msg (req_net_p0)
	);

	mem_net_req_decode #(.p_port(1), .p_single_bank(p_single_bank)) req_decode_p1 (
		.mode    (mode),
		.mem_msg (req_in_msg_p1),
		.net_msg (req_net_p1)
	);

	// banks always accept, credits do the flow control
	mem_net_router #(
		.msg_t         (mem_net_pkg::req_net_t),
		.p_credits     (p_credits),
		.p_use_credits (1)
	) req_router (
		.clk          (clk),
		.rst          (rst),
		.in_msg_0     (req_net_p0),
		.in_val_0     (req_in_val_p0),
		.in_rdy_0     (req_in_rdy_p0),
		.in_msg_1     (req_net_p1),
		.in_val_1     (req_in_val_p1),
		.in_rdy_1     (req_in_rdy_p1),
		.out_msg_0    (req_out_msg_p0),
		.out_val_0    (req_out_val_p0),
		.out_rdy_0    (1'b1),
		.out_credit_0 (req_out_credit_p0),
		.out_msg_1    (req_out_msg_p1),
		.out_val_1    (req_out_val_p1),
		.out_rdy_1    (1'b1),
		.out_credit_1 (req_out_credit_p1)
	);

	//====================================================================
	// response path
	//====================================================================

	mem_net_router #(
		.msg_t         (mem_net_pkg::resp_net_t),
		.p_credits     (p_credits),
		.p_use_credits (0)
	) resp_router (
		.clk          (clk),
		.rst          (rst),
		.in_msg_0     (resp_in_msg_p0),
		.in_val_0     (resp_in_val_p0),
		.in_rdy_0     (resp_in_rdy_p0),
		.in_msg_1     (resp_in_msg_p1),
		.in_val_1     (resp_in_val_p1),
		.in_rdy_1     (resp_in_rdy_p1),
		.out_msg_0    (resp_net_p0),
		.out_val_0    (resp_out_val_p0),
		.out_rdy_0    (resp_out_rdy_p0),
		.out_credit_0 (1'b0),
		.out_msg_1    (resp_net_p1),
		.out_val_1    (resp_out_val_p1),
		.out_rdy_1    (resp_out_rdy_p1),
		.out_credit_1 (1'b0)
	);

	mem_net_resp_result #(.p_port(0)) resp_result_p0 (
		.mode     (mode),
		.net_msg  (resp_net_p0),
		.proc_msg (resp_out_msg_p0)
	);

	mem_net_resp_result #(.p_port(1)) resp_result_p1 (
		.mode     (mode),
		.net_msg  (resp_net_p1),
		.proc_msg (resp_out_msg_p1)
	);

endmodule

`default_nettype wire

// ==== mem_net_chk.sv ====
// assertions bound into every mem_net_router instance
// credit checks apply only to a router built with credits
`timescale 1ns/1ps
`default_nettype none

module mem_net_chk #(
	parameter type msg_t         = mem_net_pkg::req_net_t,
	parameter int  p_credits     = 2,
	parameter int  p_use_credits = 1
) (
	input logic                                           clk,
	input logic                                           rst,
	input msg_t                                           in_msg_0,
	input msg_t                                           in_msg_1,
	input logic [1:0]                                     in_val,
	input logic [1:0]                                     in_rdy,
	input logic [1:0]                                     out_val,
	input logic [1:0]                                     out_rdy,
	input logic [1:0]                                     out_credit,
	input logic [1:0][$clog2(p_credits + 1)-1:0]          credit_cnt
);

	//====================================================================
	// credits
	//====================================================================

	generate
		if (p_use_credits != 0) begin : g_credit
			// credits as the bank sees them, counted from sends and returned pulses
			int bank_cnt [2];

			always_ff @(posedge clk) begin
				if (rst) begin
					bank_cnt[0] <= p_credits;
					bank_cnt[1] <= p_credits;
				end else begin
					for (int o = 0; o < 2; o++) begin
						bank_cnt[o] <= bank_cnt[o] - int'(out_val[o] && out_rdy[o])
							+ int'(out_credit[o]);
					end
				end
			end

			a_no_send_without_credit: assert property (@(posedge clk) disable iff (rst)
				(!out_val[0] || bank_cnt[0] > 0) && (!out_val[1] || bank_cnt[1] > 0))
				else $error("router output valid while its credit count is zero");

			a_credit_bound: assert property (@(posedge clk) disable iff (rst)
				(int'(credit_cnt[0]) <= p_credits) && (int'(credit_cnt[1]) <= p_credits))
				else $error("router credit count above the bank queue depth");
		end
	endgenerate

	//====================================================================
	// input handshake
	//====================================================================

	// a stalled sender keeps valid and message until accepted
	a_hold_0: assert property (@(posedge clk) disable iff (rst)
		in_val[0] && !in_rdy[0] |=> in_val[0] && $stable(in_msg_0))
		else $error("input 0 message changed or dropped while stalled");

	a_hold_1: assert property (@(posedge clk) disable iff (rst)
		in_val[1] && !in_rdy[1] |=> in_val[1] && $stable(in_msg_1))
		else $error("input 1 message changed or dropped while stalled");

endmodule

`default_nettype wire

// ==== mem_net_pkg.sv ====
// shared types for the two-port memory network with domain tags
// port p owns domain p, and the number of banks equals the number of ports
`default_nettype none

package mem_net_pkg;

	//====================================================================
	// sizes
	//====================================================================

	localparam int c_num_ports   = 2;
	localparam int c_port_nbits  = 1;

	localparam int c_opaque_nbits = 8;
	localparam int c_addr_nbits   = 32;
	localparam int c_data_nbits   = 32;

	// depth of each router input queue
	localparam int c_q_depth = 2;

	// address bit that picks the bank in shared mode
	localparam int c_bank_sel_bit = 2;

	// values of the mode input
	localparam logic c_mode_shared = 1'b0;
	localparam logic c_mode_part   = 1'b1;

	//====================================================================
	// message formats
	//====================================================================

	// processor request, 73 bits
	typedef struct packed {
		logic                      rw;
		logic [c_opaque_nbits-1:0] opaque;
		logic [c_addr_nbits-1:0]   addr;
		logic [c_data_nbits-1:0]   data;
	} mem_req_t;

	// bank response, 41 bits
	typedef struct packed {
		logic                      rw;
		logic [c_opaque_nbits-1:0] opaque;
		logic [c_data_nbits-1:0]   data;
	} mem_resp_t;

	typedef struct packed {
		logic [c_port_nbits-1:0] src;
		logic [c_port_nbits-1:0] dest;
		logic                    domain;
	} net_hdr_t;

	typedef struct packed {
		net_hdr_t hdr;
		mem_req_t body;
	} req_net_t;

	typedef struct packed {
		net_hdr_t  hdr;
		mem_resp_t body;
	} resp_net_t;

	// leak is set when the domain check wiped the data
	typedef struct packed {
		mem_resp_t resp;
		logic      domain;
		logic      leak;
	} proc_resp_t;

endpackage

`default_nettype wire

// ==== mem_net_req_decode.sv ====
// turns a processor request into a network request, purely combinational
// mode is expected to stay constant while requests are in flight
`timescale 1ns/1ps
`default_nettype none

module mem_net_req_decode #(
	parameter int p_port        = 0,
	parameter int p_single_bank = 0
) (
	input  logic                  mode,
	input  mem_net_pkg::mem_req_t mem_msg,
	output mem_net_pkg::req_net_t net_msg
);

	localparam logic [mem_net_pkg::c_port_nbits-1:0] c_src =
		mem_net_pkg::c_port_nbits'(p_port);

	// domain equals port number
	localparam logic c_domain = 1'(p_port);

	logic [mem_net_pkg::c_port_nbits-1:0] dest;

	//====================================================================
	// bank selection
	//====================================================================

	always_comb begin
		if (p_single_bank != 0) begin
			dest = '0;
		end else if (mode == mem_net_pkg::c_mode_part) begin
			// partitioned: each domain has its own bank
			dest = mem_net_pkg::c_port_nbits'(c_domain);
		end else begin
			dest = mem_net_pkg::c_port_nbits'(mem_msg.addr[mem_net_pkg::c_bank_sel_bit]);
		end
	end

	always_comb begin
		net_msg.hdr.src    = c_src;
		net_msg.hdr.dest   = dest;
		net_msg.hdr.domain = c_domain;
		net_msg.body       = mem_msg;
	end

endmodule

`default_nettype wire

// ==== mem_net_resp_result.sv ====
// strips the network header and applies the domain check for one port
// the check only acts in partitioned mode
`timescale 1ns/1ps
`default_nettype none

module mem_net_resp_result #(
	parameter int p_port = 0
) (
	input  logic                    mode,
	input  mem_net_pkg::resp_net_t  net_msg,
	output mem_net_pkg::proc_resp_t proc_msg
);

	localparam logic c_domain = 1'(p_port);

	logic leak;

	// tag from another domain in partitioned mode
	assign leak = (mode == mem_net_pkg::c_mode_part) && (net_msg.hdr.domain != c_domain);

	//====================================================================
	// unpack
	//====================================================================

	always_comb begin
		proc_msg.resp   = net_msg.body;
		proc_msg.domain = net_msg.hdr.domain;
		proc_msg.leak   = leak;
		if (leak) begin
			// nothing from the other domain may reach this port
			proc_msg.resp.data = '0;
		end
	end

endmodule

`default_nettype wire

// ==== mem_net_router.sv ====
// 2x2 router, two-entry queue per input and one output register per output
// msg_t must carry a net_hdr_t named hdr; with credits on, out_rdy must be tied high
`timescale 1ns/1ps
`default_nettype none

module mem_net_router #(
	parameter type msg_t         = mem_net_pkg::req_net_t,
	parameter int  p_credits     = 2,
	parameter int  p_use_credits = 1
) (
	input  logic clk,
	input  logic rst,

	input  msg_t in_msg_0,
	input  logic in_val_0,
	output logic in_rdy_0,

	input  msg_t in_msg_1,
	input  logic in_val_1,
	output logic in_rdy_1,

	output msg_t out_msg_0,
	output logic out_val_0,
	input  logic out_rdy_0,
	input  logic out_credit_0,

	output msg_t out_msg_1,
	output logic out_val_1,
	input  logic out_rdy_1,
	input  logic out_credit_1
);

	localparam int n = mem_net_pkg::c_num_ports;
	localparam int c_qptr_nbits = $clog2(mem_net_pkg::c_q_depth);
	localparam int c_qcnt_nbits = $clog2(mem_net_pkg::c_q_depth + 1);
	localparam int c_cnt_nbits  = $clog2(p_credits + 1);

	msg_t                           in_msg [n];
	logic [n-1:0]                   in_val;
	logic [n-1:0]                   in_rdy;
	logic [n-1:0]                   out_rdy;
	logic [n-1:0]                   out_credit;

	msg_t                           q_mem [n][mem_net_pkg::c_q_depth];
	logic [n-1:0][c_qptr_nbits-1:0] q_wptr;
	logic [n-1:0][c_qptr_nbits-1:0] q_rptr;
	logic [n-1:0][c_qcnt_nbits-1:0] q_cnt;
	logic [n-1:0]                   q_enq;
	logic [n-1:0]                   q_deq;
	msg_t                           q_head [n];
	logic [n-1:0]                   q_head_val;

	// want/grant are indexed [output][input]
	logic [n-1:0][n-1:0]            want;
	logic [n-1:0][n-1:0]            grant;
	logic [n-1:0]                   rr_pri;

	msg_t                           out_reg [n];
	logic [n-1:0]                   out_full;
	logic [n-1:0]                   out_val;
	logic [n-1:0]                   out_fire;
	logic [n-1:0][c_cnt_nbits-1:0]  credit_cnt;
	logic [n-1:0]                   credit_ok;

	assign in_msg[0]  = in_msg_0;
	assign in_msg[1]  = in_msg_1;
	assign in_val     = {in_val_1, in_val_0};
	assign out_rdy    = {out_rdy_1, out_rdy_0};
	assign out_credit = {out_credit_1, out_credit_0};

	//====================================================================
	// input queues
	//====================================================================

	always_comb begin
		for (int i = 0; i < n; i++) begin
			in_rdy[i]     = q_cnt[i] != c_qcnt_nbits'(mem_net_pkg::c_q_depth);
			q_enq[i]      = in_val[i] && in_rdy[i];
			q_head_val[i] = q_cnt[i] != '0;
			q_head[i]     = q_mem[i][q_rptr[i]];
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < n; i++) begin
			if (q_enq[i]) begin
				q_mem[i][q_wptr[i]] <= in_msg[i];
			end
		end
	end

	// pointers wrap on their own since the depth is a power of two
	always_ff @(posedge clk) begin
		if (rst) begin
			q_wptr <= '0;
			q_rptr <= '0;
			q_cnt  <= '0;
		end else begin
			for (int i = 0; i < n; i++) begin
				q_wptr[i] <= q_wptr[i] + c_qptr_nbits'(q_enq[i]);
				q_rptr[i] <= q_rptr[i] + c_qptr_nbits'(q_deq[i]);
				q_cnt[i]  <= q_cnt[i] + c_qcnt_nbits'(q_enq[i]) - c_qcnt_nbits'(q_deq[i]);
			end
		end
	end

	//====================================================================
	// round-robin arbitration per output
	//====================================================================

	always_comb begin
		for (int o = 0; o < n; o++) begin
			for (int i = 0; i < n; i++) begin
				want[o][i] = q_head_val[i] &&
					(q_head[i].hdr.dest == mem_net_pkg::c_port_nbits'(o));
			end
			grant[o] = '0;
			// load only into a free register, or one that empties this cycle
			if (!out_full[o] || out_fire[o]) begin
				if (want[o][rr_pri[o]]) begin
					grant[o][rr_pri[o]] = 1'b1;
				end else if (want[o][~rr_pri[o]]) begin
					grant[o][~rr_pri[o]] = 1'b1;
				end
			end
		end
		q_deq = grant[0] | grant[1];
	end

	always_ff @(posedge clk) begin
		for (int o = 0; o < n; o++) begin
			if (|grant[o]) begin
				out_reg[o] <= q_head[grant[o][1]];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			out_full <= '0;
			rr_pri   <= '0;
		end else begin
			for (int o = 0; o < n; o++) begin
				out_full[o] <= (|grant[o]) || (out_full[o] && !out_fire[o]);
				// winner drops to lowest priority
				if (|grant[o]) begin
					rr_pri[o] <= ~grant[o][1];
				end
			end
		end
	end

	//====================================================================
	// output flow control
	//====================================================================

	generate
		if (p_use_credits != 0) begin : g_credit
			always_ff @(posedge clk) begin
				if (rst) begin
					credit_cnt <= {n{c_cnt_nbits'(p_credits)}};
				end else begin
					// a send and a returned credit may land in the same cycle
					for (int o = 0; o < n; o++) begin
						credit_cnt[o] <= credit_cnt[o] - c_cnt_nbits'(out_fire[o])
							+ c_cnt_nbits'(out_credit[o]);
					end
				end
			end
			always_comb begin
				for (int o = 0; o < n; o++) begin
					credit_ok[o] = credit_cnt[o] != '0;
				end
			end
		end else begin : g_no_credit
			assign credit_cnt = {n{c_cnt_nbits'(p_credits)}};
			assign credit_ok  = '1;
		end
	endgenerate

	assign out_val  = out_full & credit_ok;
	assign out_fire = out_val & out_rdy;

	assign out_msg_0 = out_reg[0];
	assign out_msg_1 = out_reg[1];
	assign out_val_0 = out_val[0];
	assign out_val_1 = out_val[1];
	assign in_rdy_0  = in_rdy[0];
	assign in_rdy_1  = in_rdy[1];

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build and run the mem_net testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_mem_net -f vlog.f
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

out=$(./obj_dir/Vtb_mem_net)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "SIMULATION PASSED"; then
	exit 0
fi
exit 1

// ==== tb_mem_net.sv ====
// testbench for mem_net with two bank models and a scoreboard
// request opaque fields are per-port counters, used to match responses
`timescale 1ns/1ps
`default_nettype none

module tb_mem_net;

	localparam int          c_credits = 2;
	localparam int          c_reqs    = 40;
	localparam logic [31:0] c_pattern = 32'h5a5a_c3c3;
	// tests 1..3 use 2*c_reqs, test 4 twice that, test 5 three requests
	localparam int          c_planned = 2 * c_reqs * 5 + 3;

	logic clk;
	logic rst;
	logic mode;

	mem_net_pkg::mem_req_t   req_msg [2];
	logic [1:0]              req_val;
	logic [1:0]              req_rdy;
	mem_net_pkg::proc_resp_t rsp_msg [2];
	logic [1:0]              rsp_val;
	logic [1:0]              rsp_rdy;
	mem_net_pkg::req_net_t   bank_req [2];
	logic [1:0]              bank_req_val;
	logic [1:0]              bank_credit;
	mem_net_pkg::resp_net_t  bank_rsp [2];
	logic [1:0]              bank_rsp_val;
	logic [1:0]              bank_rsp_rdy;

	// scoreboard state
	mem_net_pkg::mem_req_t   exp_req [2][2][$];
	mem_net_pkg::proc_resp_t exp_rsp [2][2][$];
	mem_net_pkg::req_net_t   bank_q [2][$];
	int         reqs_left [2];
	logic [7:0] tag [2];
	logic [1:0] req_fired;
	logic [1:0] rsp_fired;
	int         credit_pending [2];
	int         rx [2];
	int         issued;
	int         finished;
	int         errors;
	int         tests_failed;
	int         leaks_seen;
	int         flips;
	bit         bank_en;
	bit         credit_slow;
	bit         rdy_drop;
	bit         flip_en;
	bit         force_bank0;

	mem_net #(.p_credits(c_credits), .p_single_bank(0)) u_mem_net (
		.clk (clk), .rst (rst), .mode (mode),
		.req_in_msg_p0 (req_msg[0]), .req_in_val_p0 (req_val[0]), .req_in_rdy_p0 (req_rdy[0]),
		.resp_out_msg_p0 (rsp_msg[0]), .resp_out_val_p0 (rsp_val[0]),
		.resp_out_rdy_p0 (rsp_rdy[0]),
		.req_in_msg_p1 (req_msg[1]), .req_in_val_p1 (req_val[1]), .req_in_rdy_p1 (req_rdy[1]),
		.resp_out_msg_p1 (rsp_msg[1]), .resp_out_val_p1 (rsp_val[1]),
		.resp_out_rdy_p1 (rsp_rdy[1]),
		.req_out_msg_p0 (bank_req[0]), .req_out_val_p0 (bank_req_val[0]),
		.req_out_credit_p0 (bank_credit[0]),
		.resp_in_msg_p0 (bank_rsp[0]), .resp_in_val_p0 (bank_rsp_val[0]),
		.resp_in_rdy_p0 (bank_rsp_rdy[0]),
		.req_out_msg_p1 (bank_req[1]), .req_out_val_p1 (bank_req_val[1]),
		.req_out_credit_p1 (bank_credit[1]),
		.resp_in_msg_p1 (bank_rsp[1]), .resp_in_val_p1 (bank_rsp_val[1]),
		.resp_in_rdy_p1 (bank_rsp_rdy[1])
	);

	bind mem_net_router mem_net_chk #(
		.msg_t (msg_t), .p_credits (p_credits), .p_use_credits (p_use_credits)
	) u_chk (
		.clk (clk), .rst (rst), .in_msg_0 (in_msg_0), .in_msg_1 (in_msg_1),
		.in_val (in_val), .in_rdy (in_rdy), .out_val (out_val), .out_rdy (out_rdy),
		.out_credit (out_credit), .credit_cnt (credit_cnt)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic report_mismatch(input string sig, input logic [127:0] exp,
		input logic [127:0] got);
		$display("Mismatch at %0t: %s expected %h got %h", $time, sig, exp, got);
		errors++;
	endtask

	task automatic report_error(input string what);
		$display("Error at %0t: %s", $time, what);
		errors++;
	endtask

	//====================================================================
	// processor request side
	//====================================================================

	task automatic drive_requests();
		int b;
		for (int p = 0; p < 2; p++) begin
			if (req_fired[p]) req_val[p] = 1'b0;
			if (!req_val[p] && reqs_left[p] > 0 && $urandom % 2 == 0) begin
				req_msg[p].rw     = 1'($urandom);
				req_msg[p].opaque = tag[p];
				req_msg[p].addr   = $urandom;
				req_msg[p].data   = $urandom;
				if (force_bank0) req_msg[p].addr[2] = 1'b0;
				tag[p]++;
				req_val[p] = 1'b1;
			end
			req_fired[p] = req_val[p] && req_rdy[p];
			if (req_fired[p]) begin
				reqs_left[p]--;
				issued++;
				// partitioned: own bank, shared: address bit 2
				if (mode) b = p;
				else b = int'(req_msg[p].addr[2]);
				exp_req[p][b].push_back(req_msg[p]);
			end
		end
	endtask

	//====================================================================
	// bank models
	//====================================================================

	task automatic bank_receive();
		mem_net_pkg::req_net_t m;
		mem_net_pkg::mem_req_t e;
		int s;
		for (int b = 0; b < 2; b++) begin
			if (bank_req_val[b]) begin
				m = bank_req[b];
				s = int'(m.hdr.src);
				rx[b]++;
				if (m.hdr.dest != 1'(b)) report_mismatch($sformatf("req_out_msg_p%0d.hdr.dest", b),
					128'(b), 128'(m.hdr.dest));
				if (m.hdr.domain != m.hdr.src) report_mismatch(
					$sformatf("req_out_msg_p%0d.hdr.domain", b), 128'(m.hdr.src),
					128'(m.hdr.domain));
				// entries still queued plus freed entries whose credit is not yet returned
				if (bank_q[b].size() + credit_pending[b] >= c_credits)
					report_error($sformatf("bank %0d got more than %0d outstanding", b, c_credits));
				if (exp_req[s][b].size() == 0) begin
					report_error($sformatf("bank %0d got an unexpected request from port %0d", b, s));
				end else begin
					e = exp_req[s][b].pop_front();
					if (m.body != e) report_mismatch($sformatf("req_out_msg_p%0d.body", b),
						128'(e), 128'(m.body));
				end
				bank_q[b].push_back(m);
			end
		end
	endtask

	task automatic bank_respond();
		mem_net_pkg::req_net_t   r;
		mem_net_pkg::proc_resp_t e;
		int d;
		for (int b = 0; b < 2; b++) begin
			bank_credit[b] = 1'b0;
			if (credit_pending[b] > 0 && (!credit_slow || $urandom % 4 == 0)) begin
				bank_credit[b] = 1'b1;
				credit_pending[b]--;
			end
			if (rsp_fired[b]) bank_rsp_val[b] = 1'b0;
			if (!bank_rsp_val[b] && bank_en && bank_q[b].size() > 0 && $urandom % 3 == 0) begin
				r = bank_q[b].pop_front();
				credit_pending[b]++;
				bank_rsp[b].hdr.src    = 1'(b);
				bank_rsp[b].hdr.dest   = r.hdr.src;
				bank_rsp[b].hdr.domain = r.hdr.domain;
				if (flip_en && b == 1 && $urandom % 2 == 0) begin
					bank_rsp[b].hdr.domain = ~r.hdr.domain;
					flips++;
				end
				bank_rsp[b].body.rw     = r.body.rw;
				bank_rsp[b].body.opaque = r.body.opaque;
				bank_rsp[b].body.data   = r.body.rw ? r.body.data : (r.body.addr ^ c_pattern);
				bank_rsp_val[b] = 1'b1;
			end
			rsp_fired[b] = bank_rsp_val[b] && bank_rsp_rdy[b];
			if (rsp_fired[b]) begin
				d = int'(bank_rsp[b].hdr.dest);
				e.resp   = bank_rsp[b].body;
				e.domain = bank_rsp[b].hdr.domain;
				e.leak   = mode && (bank_rsp[b].hdr.domain != bank_rsp[b].hdr.dest);
				if (e.leak) e.resp.data = '0;
				exp_rsp[d][b].push_back(e);
			end
		end
	endtask

	//====================================================================
	// processor response side
	//====================================================================

	task automatic take_responses();
		mem_net_pkg::proc_resp_t got;
		mem_net_pkg::proc_resp_t e;
		int b;
		for (int p = 0; p < 2; p++) begin
			rsp_rdy[p] = rdy_drop ? 1'($urandom) : 1'b1;
			if (rsp_val[p] && rsp_rdy[p]) begin
				got = rsp_msg[p];
				b = -1;
				if (exp_rsp[p][0].size() > 0 && exp_rsp[p][0][0].resp.opaque == got.resp.opaque)
					b = 0;
				else if (exp_rsp[p][1].size() > 0 &&
					exp_rsp[p][1][0].resp.opaque == got.resp.opaque)
					b = 1;
				if (b < 0) begin
					report_error($sformatf("port %0d got a response with opaque %h out of order",
						p, got.resp.opaque));
				end else begin
					e = exp_rsp[p][b].pop_front();
					if (got != e) report_mismatch($sformatf("resp_out_msg_p%0d", p),
						128'(e), 128'(got));
				end
				if (got.leak) leaks_seen++;
				finished++;
			end
		end
	endtask

	always @(negedge clk) begin
		if (rst) begin
			req_val      = '0;
			req_fired    = '0;
			rsp_fired    = '0;
			bank_rsp_val = '0;
			bank_credit  = '0;
			rsp_rdy      = '1;
			for (int b = 0; b < 2; b++) begin
				credit_pending[b] = 0;
				bank_q[b].delete();
			end
		end else begin
			drive_requests();
			bank_receive();
			bank_respond();
			take_responses();
		end
	end

	//====================================================================
	// tests
	//====================================================================

	task automatic check_drained();
		for (int p = 0; p < 2; p++) begin
			for (int b = 0; b < 2; b++) begin
				if (exp_req[p][b].size() != 0 || exp_rsp[p][b].size() != 0)
					report_error($sformatf("messages lost between port %0d and bank %0d", p, b));
			end
		end
	endtask

	task automatic run_traffic(input logic m, input bit cs, input bit rd, input bit fl);
		mode        = m;
		credit_slow = cs;
		rdy_drop    = rd;
		flip_en     = fl;
		bank_en     = 1'b1;
		flips       = 0;
		leaks_seen  = 0;
		issued      = 0;
		finished    = 0;
		reqs_left[0] = c_reqs;
		reqs_left[1] = c_reqs;
		while (finished < 2 * c_reqs) @(negedge clk);
		repeat (5) @(negedge clk);
		check_drained();
	endtask

	task automatic end_test(input int num, input string name, input int err0);
		if (errors != err0) tests_failed++;
		$display("test %0d %s: %s, %0d errors", num, name,
			(errors == err0) ? "ok" : "failed", errors - err0);
	endtask

	initial begin
		int err0;
		void'($urandom(32'h317b));
		rst = 1'b1;
		mode = 1'b0;
		req_val = '0;
		req_msg[0] = '0;
		req_msg[1] = '0;
		rsp_rdy = '1;
		bank_rsp[0] = '0;
		bank_rsp[1] = '0;
		bank_rsp_val = '0;
		bank_credit = '0;
		req_fired = '0;
		rsp_fired = '0;
		tag[0] = '0;
		tag[1] = '0;
		reqs_left[0] = 0;
		reqs_left[1] = 0;
		errors = 0;
		tests_failed = 0;
		bank_en = 1'b0;
		force_bank0 = 1'b0;
		repeat (3) @(negedge clk);
		rst = 1'b0;

		err0 = errors;
		run_traffic(1'b0, 1'b0, 1'b0, 1'b0);
		end_test(1, "shared mode routing", err0);

		err0 = errors;
		run_traffic(1'b1, 1'b0, 1'b0, 1'b0);
		end_test(2, "partitioned mode routing", err0);

		err0 = errors;
		run_traffic(1'b0, 1'b1, 1'b1, 1'b0);
		end_test(3, "back-pressure", err0);

		err0 = errors;
		run_traffic(1'b1, 1'b0, 1'b0, 1'b1);
		if (flips == 0 || leaks_seen != flips)
			report_error($sformatf("partitioned: %0d tags altered, %0d leaks", flips, leaks_seen));
		run_traffic(1'b0, 1'b0, 1'b0, 1'b1);
		if (flips == 0 || leaks_seen != 0)
			report_error($sformatf("shared: %0d tags altered, %0d leaks", flips, leaks_seen));
		end_test(4, "domain check", err0);

		// credits after reset, banks hold their queues at first
		err0 = errors;
		bank_en = 1'b0;
		flip_en = 1'b0;
		mode = 1'b0;
		force_bank0 = 1'b1;
		rst = 1'b1;
		repeat (3) @(negedge clk);
		rst = 1'b0;
		if (bank_req_val != '0 || rsp_val != '0)
			report_error("a valid output is high right after reset");
		if (req_rdy != '1 || bank_rsp_rdy != '1)
			report_error("a ready output is low right after reset");
		issued = 0;
		finished = 0;
		rx[0] = 0;
		rx[1] = 0;
		reqs_left[0] = 3;
		while (rx[0] < 2) @(negedge clk);
		repeat (20) @(negedge clk);
		if (rx[0] != 2) report_error("bank 0 received a request without a credit");
		if (issued != 3) report_error("port 0 could not hand over its third request");
		bank_en = 1'b1;
		while (finished < 3) @(negedge clk);
		if (rx[0] != 3) report_error("third request never reached bank 0");
		check_drained();
		end_test(5, "credits after reset", err0);

		$display("tests run 5, failed %0d, errors %0d", tests_failed, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

	// each planned transaction gets 200 cycles
	initial begin
		#(c_planned * 200 * 20 + 2000);
		$display("watchdog timeout, the tests did not finish in time");
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
mem_net_pkg.sv
mem_net_req_decode.sv
mem_net_router.sv
mem_net_resp_result.sv
mem_net.sv
mem_net_chk.sv
tb_mem_net.sv
